// File: Bender.yml
package:
  name: vlane

export_include_dirs:
  - source

sources:
  # RTL, package first
  - source/vlane_pkg.sv
  - source/vlane_issue.sv
  - source/vlane_ex_pipe.sv
  - source/vlane_rdc_wb.sv
  - source/vlane_top.sv

  # Testbench
  - target: simulation
    files:
      - sim/vlane_clkgen.sv
      - sim/vlane_tb.sv

// File: flist.f
+incdir+source
source/vlane_pkg.sv
source/vlane_issue.sv
source/vlane_ex_pipe.sv
source/vlane_rdc_wb.sv
source/vlane_top.sv
sim/vlane_clkgen.sv
sim/vlane_tb.sv

// File: sim/vlane_clkgen.sv
// Clock and reset source for the vector lane testbench
// 10 ns clock, rst_n held low for the first 4 cycles

module vlane_clkgen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Release on a rising edge, same as the rest of the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: sim/vlane_tb.sv
// Directed testbench for the vector lane
// Drives vlane_top with element-wise, masked and reduction traffic and
// checks writebacks and both forward points against a reference model

`include "vlane_defines.svh"

module vlane_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import vlane_pkg::*;

    // Test lengths in issue cycles
    localparam int N_RAND = 36;
    localparam int N_MASK = 24;
    localparam int N_FWD  = 8;
    localparam int N_RDC  = 4 * (6 + 4 + 1 + 1);
    localparam int N_MIX  = 8;
    localparam int DRAIN  = `VLANE_STAGES + 4;
    localparam int RUN_CYCLES = 8 + N_RAND + N_MASK + N_FWD + N_RDC + N_MIX + 6 * DRAIN;
    localparam int WATCHDOG_NS = (RUN_CYCLES + 100) * 10;

    logic        clk;
    logic        rst_n;
    logic        valid_i;
    vlane_op_e   op_i;
    vlane_word_t a_i;
    vlane_word_t b_i;
    logic        active_i;
    logic        head_i;
    logic        end_i;
    logic        frw_a_en_o;
    vlane_word_t frw_a_data_o;
    logic        frw_b_en_o;
    vlane_word_t frw_b_data_o;
    logic        wr_en_o;
    vlane_word_t wr_data_o;
    logic        rdc_done_o;

    integer      seed = 61;
    int          cyc = 0;
    int          err_cnt = 0;
    int          check_cnt = 0;
    // Running fold of the current reduction run, scalar first
    vlane_word_t run_acc;

    // Expected writebacks, oldest first
    vlane_word_t wb_data_q[$];
    logic        wb_done_q[$];
    int          wb_cyc_q[$];
    // Expected late forwards
    vlane_word_t fb_data_q[$];
    int          fb_cyc_q[$];

    vlane_op_e elem_ops[6] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MUL};
    vlane_op_e rdc_ops[4]  = '{OP_RSUM, OP_RAND, OP_ROR, OP_RXOR};

    vlane_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

    vlane_top UUT (
        .clk(clk), .rst_n(rst_n),
        .valid_i(valid_i), .op_i(op_i), .a_i(a_i), .b_i(b_i),
        .active_i(active_i), .head_i(head_i), .end_i(end_i),
        .frw_a_en_o(frw_a_en_o), .frw_a_data_o(frw_a_data_o),
        .frw_b_en_o(frw_b_en_o), .frw_b_data_o(frw_b_data_o),
        .wr_en_o(wr_en_o), .wr_data_o(wr_data_o), .rdc_done_o(rdc_done_o)
    );

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic vlane_word_t elem_result(vlane_op_e op, vlane_word_t a, vlane_word_t b);
        vlane_word_t r;
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            // Low 32 bits of the product
            default: r = a * b;
        endcase
        return r;
    endfunction

    function automatic vlane_word_t rdc_combine(vlane_op_e op, vlane_word_t x, vlane_word_t y);
        case (op)
            OP_RAND: return x & y;
            OP_ROR:  return x | y;
            OP_RXOR: return x ^ y;
            default: return x + y;
        endcase
    endfunction

    function automatic logic rand_bit();
        return ($random(seed) & 1) != 0;
    endfunction

    task automatic report_mismatch(string sig, vlane_word_t exp, vlane_word_t act);
        $display("ERR %0t %s expected %h got %h", $time, sig, exp, act);
        err_cnt++;
    endtask

    task automatic report_failure(string msg);
        $display("%0t %s", $time, msg);
        err_cnt++;
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    // One element per call, back to back when called in a row
    task automatic issue_elem(input vlane_op_e op, input vlane_word_t a, input vlane_word_t b,
                              input logic act, input logic hd, input logic en);
        logic        is_rdc;
        logic        fa_exp;
        vlane_word_t res;
        vlane_word_t wb;
        int          wb_cyc;
        is_rdc = op inside {OP_RSUM, OP_RAND, OP_ROR, OP_RXOR};
        res    = elem_result(op, a, b);
        fa_exp = act && !is_rdc && (op != OP_MUL);
        @(posedge clk);
        valid_i  <= 1'b1;
        op_i     <= op;
        a_i      <= a;
        b_i      <= b;
        active_i <= act;
        head_i   <= hd;
        end_i    <= en;
        // Issue cycle is the next one, writeback four cycles later
        wb_cyc = cyc + 1 + `VLANE_STAGES;
        if (is_rdc) begin
            if (hd) run_acc = a;
            if (act) run_acc = rdc_combine(op, run_acc, b);
            if (en) begin
                wb_data_q.push_back(run_acc);
                wb_done_q.push_back(1'b1);
                wb_cyc_q.push_back(wb_cyc);
            end
        end else begin
            wb = act ? res : '0;
            wb_data_q.push_back(wb);
            wb_done_q.push_back(1'b0);
            wb_cyc_q.push_back(wb_cyc);
            fb_data_q.push_back(wb);
            fb_cyc_q.push_back(wb_cyc - 1);
        end
        // Early forward is combinational in the issue cycle
        @(negedge clk);
        check_cnt++;
        if (frw_a_en_o !== fa_exp) report_mismatch("frw_a_en_o", fa_exp, frw_a_en_o);
        if (fa_exp && frw_a_data_o !== res) report_mismatch("frw_a_data_o", res, frw_a_data_o);
    endtask

    // Idle the issue port until every expected result has been seen
    task automatic drain();
        @(posedge clk);
        valid_i <= 1'b0;
        head_i  <= 1'b0;
        end_i   <= 1'b0;
        while (wb_cyc_q.size() != 0 || fb_cyc_q.size() != 0) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic finish_test(string name, int errs_before);
        $display("test %-16s done, %0d errors", name, err_cnt - errs_before);
    endtask

    task automatic run_reduction(vlane_op_e op, int len, logic head_act);
        logic act;
        for (int i = 0; i < len; i++) begin
            act = (i == 0) ? head_act : rand_bit();
            issue_elem(op, $random(seed), $random(seed), act, i == 0, i == len - 1);
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_reset_idle();
        int e0;
        e0 = err_cnt;
        repeat (3) begin
            @(negedge clk);
            check_cnt++;
            if (wr_en_o !== 1'b0) report_mismatch("wr_en_o", 0, wr_en_o);
            if (rdc_done_o !== 1'b0) report_mismatch("rdc_done_o", 0, rdc_done_o);
            if (frw_b_en_o !== 1'b0) report_mismatch("frw_b_en_o", 0, frw_b_en_o);
        end
        finish_test("reset_idle", e0);
    endtask

    task automatic test_random_elem();
        int e0;
        e0 = err_cnt;
        for (int i = 0; i < N_RAND; i++) begin
            issue_elem(elem_ops[i % 6], $random(seed), $random(seed), 1'b1, 1'b0, 1'b0);
        end
        drain();
        finish_test("random_elem", e0);
    endtask

    task automatic test_masked();
        int e0;
        e0 = err_cnt;
        for (int i = 0; i < N_MASK; i++) begin
            issue_elem(elem_ops[$unsigned($random(seed)) % 6], $random(seed), $random(seed),
                       rand_bit(), 1'b0, 1'b0);
        end
        drain();
        finish_test("masked", e0);
    endtask

    // Early forward only for active single-cycle ops
    task automatic test_early_fwd();
        int e0;
        e0 = err_cnt;
        for (int i = 0; i < 5; i++) begin
            issue_elem(elem_ops[i], $random(seed), $random(seed), 1'b1, 1'b0, 1'b0);
        end
        issue_elem(OP_MUL, $random(seed), $random(seed), 1'b1, 1'b0, 1'b0);
        issue_elem(OP_ADD, $random(seed), $random(seed), 1'b0, 1'b0, 1'b0);
        issue_elem(OP_RSUM, $random(seed), $random(seed), 1'b1, 1'b1, 1'b1);
        drain();
        finish_test("early_fwd", e0);
    endtask

    task automatic test_reductions();
        int e0;
        e0 = err_cnt;
        for (int k = 0; k < 4; k++) begin
            run_reduction(rdc_ops[k], 6, 1'b1);
            run_reduction(rdc_ops[k], 4, 1'b0);
            run_reduction(rdc_ops[k], 1, 1'b1);
            run_reduction(rdc_ops[k], 1, 1'b0);
        end
        drain();
        finish_test("reductions", e0);
    endtask

    // Element-wise ops between the elements of one run
    task automatic test_interleave();
        int e0;
        e0 = err_cnt;
        issue_elem(OP_RXOR, $random(seed), $random(seed), 1'b1, 1'b1, 1'b0);
        issue_elem(OP_MUL, $random(seed), $random(seed), 1'b1, 1'b0, 1'b0);
        issue_elem(OP_RXOR, $random(seed), $random(seed), 1'b1, 1'b0, 1'b0);
        issue_elem(OP_SUB, $random(seed), $random(seed), 1'b1, 1'b0, 1'b0);
        issue_elem(OP_AND, $random(seed), $random(seed), 1'b0, 1'b0, 1'b0);
        issue_elem(OP_RXOR, $random(seed), $random(seed), 1'b0, 1'b0, 1'b0);
        issue_elem(OP_RXOR, $random(seed), $random(seed), 1'b1, 1'b0, 1'b1);
        issue_elem(OP_ADD, $random(seed), $random(seed), 1'b1, 1'b0, 1'b0);
        drain();
        finish_test("interleave", e0);
    endtask

    // --------------------------------------------------
    // Output monitor, sampled at the falling edge
    // --------------------------------------------------
    always @(negedge clk) begin
        cyc = cyc + 1;
        if (wr_en_o === 1'b1) begin
            if (wb_cyc_q.size() == 0) begin
                report_failure("writeback seen with no result expected");
            end else begin
                check_cnt++;
                if (wr_data_o !== wb_data_q[0]) report_mismatch("wr_data_o", wb_data_q[0], wr_data_o);
                if (rdc_done_o !== wb_done_q[0]) report_mismatch("rdc_done_o", wb_done_q[0], rdc_done_o);
                if (cyc != wb_cyc_q[0]) report_mismatch("wr_en_o cycle", wb_cyc_q[0], cyc);
                void'(wb_data_q.pop_front());
                void'(wb_done_q.pop_front());
                void'(wb_cyc_q.pop_front());
            end
        end else if (wb_cyc_q.size() != 0 && wb_cyc_q[0] < cyc) begin
            report_failure("expected writeback never arrived");
            void'(wb_data_q.pop_front());
            void'(wb_done_q.pop_front());
            void'(wb_cyc_q.pop_front());
        end
        if (rdc_done_o === 1'b1 && wr_en_o !== 1'b1) report_failure("rdc_done_o without wr_en_o");
        // Late forward point
        if (frw_b_en_o === 1'b1) begin
            if (fb_cyc_q.size() == 0) begin
                report_failure("late forward seen with no result expected");
            end else begin
                check_cnt++;
                if (frw_b_data_o !== fb_data_q[0]) begin
                    report_mismatch("frw_b_data_o", fb_data_q[0], frw_b_data_o);
                end
                if (cyc != fb_cyc_q[0]) report_mismatch("frw_b_en_o cycle", fb_cyc_q[0], cyc);
                void'(fb_data_q.pop_front());
                void'(fb_cyc_q.pop_front());
            end
        end else if (fb_cyc_q.size() != 0 && fb_cyc_q[0] < cyc) begin
            report_failure("expected late forward never arrived");
            void'(fb_data_q.pop_front());
            void'(fb_cyc_q.pop_front());
        end
    end

    // --------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------
    initial begin
        valid_i  = 1'b0;
        op_i     = OP_ADD;
        a_i      = '0;
        b_i      = '0;
        active_i = 1'b0;
        head_i   = 1'b0;
        end_i    = 1'b0;
        run_acc  = '0;
        wait (rst_n === 1'b1);
        test_reset_idle();
        test_random_elem();
        test_masked();
        test_early_fwd();
        test_reductions();
        test_interleave();
        $display("%0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: source/vlane_defines.svh
// Width and latency constants for the vector lane
// Include wherever the lane widths or the pipeline depth are needed

`ifndef VLANE_DEFINES_SVH
`define VLANE_DEFINES_SVH

// --------------------------------------------------
// Datapath widths
// --------------------------------------------------

// Element width, one operand or one result
`define VLANE_DATA_W 32

// Half word, used to split the multiply
// into 16x16 partial products
`define VLANE_HALF_W 16

// --------------------------------------------------
// Pipeline depth
// --------------------------------------------------

// Issue to writeback latency in cycles
// EX2, EX3, EX4 and the writeback register
`define VLANE_STAGES 4

`endif

// File: source/vlane_ex_pipe.sv
// Middle stages EX2 to EX4 of the vector lane
// Combines the multiply partial products in EX2, carries the element
// through EX3 and EX4 and drives the late forward point

`include "vlane_defines.svh"

module vlane_ex_pipe (
    input  logic                   clk,
    input  logic                   rst_n,
    // EX2 stage in
    input  logic                   ex2_valid_i,
    input  vlane_pkg::vlane_op_e   ex2_op_i,
    input  logic                   ex2_active_i,
    input  logic                   ex2_head_i,
    input  logic                   ex2_end_i,
    input  logic                   ex2_done_i,
    input  vlane_pkg::vlane_word_t ex2_res_i,
    input  vlane_pkg::vlane_word_t ex2_pp_ll_i,
    input  vlane_pkg::vlane_word_t ex2_pp_lh_i,
    input  vlane_pkg::vlane_word_t ex2_pp_hl_i,
    input  vlane_pkg::vlane_word_t ex2_scalar_i,
    // EX4 stage out
    output logic                   ex4_valid_o,
    output vlane_pkg::vlane_op_e   ex4_op_o,
    output logic                   ex4_active_o,
    output logic                   ex4_head_o,
    output logic                   ex4_end_o,
    output vlane_pkg::vlane_word_t ex4_res_o,
    output vlane_pkg::vlane_word_t ex4_scalar_o,
    // Late forward point
    output logic                   frw_b_en_o,
    output vlane_pkg::vlane_word_t frw_b_data_o
);
    import vlane_pkg::*;

    logic        mul_pend;
    vlane_word_t mul_lo;
    vlane_word_t ex2_val;

    logic        ex3_valid;
    vlane_op_e   ex3_op;
    logic        ex3_active;
    logic        ex3_head;
    logic        ex3_end;
    vlane_word_t ex3_res;
    vlane_word_t ex3_scalar;

    // --------------------------------------------------
    // EX2 multiply combine
    // --------------------------------------------------
    assign mul_pend = ex2_valid_i && (ex2_op_i == OP_MUL);

    // Cross products only reach the upper half of the low word
    assign mul_lo = ex2_pp_ll_i
                  + (ex2_pp_lh_i << `VLANE_HALF_W)
                  + (ex2_pp_hl_i << `VLANE_HALF_W);

    // Finished results skip the combine
    assign ex2_val = ex2_done_i ? ex2_res_i : mul_lo;

    // --------------------------------------------------
    // EX2/EX3 register
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex3_valid  <= 1'b0;
            ex3_op     <= OP_ADD;
            ex3_active <= 1'b0;
            ex3_head   <= 1'b0;
            ex3_end    <= 1'b0;
        end else begin
            ex3_valid  <= ex2_valid_i;
            ex3_op     <= ex2_op_i;
            ex3_active <= ex2_active_i;
            ex3_head   <= ex2_head_i;
            ex3_end    <= ex2_end_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ex2_valid_i) begin
            ex3_res    <= ex2_val;
            ex3_scalar <= ex2_scalar_i;
        end
    end

    // --------------------------------------------------
    // EX3/EX4 register
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex4_valid_o  <= 1'b0;
            ex4_op_o     <= OP_ADD;
            ex4_active_o <= 1'b0;
            ex4_head_o   <= 1'b0;
            ex4_end_o    <= 1'b0;
        end else begin
            ex4_valid_o  <= ex3_valid;
            ex4_op_o     <= ex3_op;
            ex4_active_o <= ex3_active;
            ex4_head_o   <= ex3_head;
            ex4_end_o    <= ex3_end;
        end
    end

    always_ff @(posedge clk) begin
        if (ex3_valid) begin
            ex4_res_o    <= ex3_res;
            ex4_scalar_o <= ex3_scalar;
        end
    end

    // Late forward, one cycle ahead of writeback
    // Reductions are still being folded, so they stay off
    assign frw_b_en_o   = ex4_valid_o && !op_is_rdc(ex4_op_o);
    assign frw_b_data_o = ex4_active_o ? ex4_res_o : '0;

    // Issue must never flag a multiply as finished
    a_mul_not_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(mul_pend && ex2_done_i)
    ) else $error("multiply reached EX2 marked done");

endmodule

// File: source/vlane_issue.sv
// Issue stage of the vector lane
// Decodes the element, runs the single-cycle ALU or splits the multiply,
// drives the early forward point and holds the EX1/EX2 register

`include "vlane_defines.svh"

module vlane_issue (
    input  logic                  clk,
    input  logic                  rst_n,
    // Issue side
    input  logic                  valid_i,
    input  vlane_pkg::vlane_op_e  op_i,
    input  vlane_pkg::vlane_word_t a_i,
    input  vlane_pkg::vlane_word_t b_i,
    input  logic                  active_i,
    input  logic                  head_i,
    input  logic                  end_i,
    // Early forward point
    output logic                  frw_a_en_o,
    output vlane_pkg::vlane_word_t frw_a_data_o,
    // EX2 stage
    output logic                  ex2_valid_o,
    output vlane_pkg::vlane_op_e  ex2_op_o,
    output logic                  ex2_active_o,
    output logic                  ex2_head_o,
    output logic                  ex2_end_o,
    output logic                  ex2_done_o,
    output vlane_pkg::vlane_word_t ex2_res_o,
    output vlane_pkg::vlane_word_t ex2_pp_ll_o,
    output vlane_pkg::vlane_word_t ex2_pp_lh_o,
    output vlane_pkg::vlane_word_t ex2_pp_hl_o,
    output vlane_pkg::vlane_word_t ex2_scalar_o
);
    import vlane_pkg::*;

    logic                     is_rdc;
    logic                     single_cyc;
    logic [`VLANE_HALF_W-1:0] a_lo;
    logic [`VLANE_HALF_W-1:0] a_hi;
    logic [`VLANE_HALF_W-1:0] b_lo;
    logic [`VLANE_HALF_W-1:0] b_hi;
    vlane_word_t              alu_res;
    vlane_word_t              pp_ll;
    vlane_word_t              pp_lh;
    vlane_word_t              pp_hl;

    // --------------------------------------------------
    // Decode and EX1 datapath
    // --------------------------------------------------
    assign is_rdc     = op_is_rdc(op_i);
    assign single_cyc = !is_rdc && (op_i != OP_MUL);

    // Operand halves for the partial products
    assign a_lo = a_i[`VLANE_HALF_W-1:0];
    assign a_hi = a_i[`VLANE_DATA_W-1:`VLANE_HALF_W];
    assign b_lo = b_i[`VLANE_HALF_W-1:0];
    assign b_hi = b_i[`VLANE_DATA_W-1:`VLANE_HALF_W];

    // Low word needs only these three, hi*hi lands above bit 31
    assign pp_ll = a_lo * b_lo;
    assign pp_lh = a_lo * b_hi;
    assign pp_hl = a_hi * b_lo;

    always_comb begin
        case (op_i)
            OP_ADD:  alu_res = a_i + b_i;
            OP_SUB:  alu_res = a_i - b_i;
            OP_AND:  alu_res = a_i & b_i;
            OP_OR:   alu_res = a_i | b_i;
            OP_XOR:  alu_res = a_i ^ b_i;
            // Multiply finishes in EX2
            OP_MUL:  alu_res = '0;
            // Reductions carry the element, folding happens at EX4
            default: alu_res = b_i;
        endcase
    end

    // Early forward, active single-cycle results only
    assign frw_a_en_o   = valid_i && active_i && single_cyc;
    assign frw_a_data_o = alu_res;

    // --------------------------------------------------
    // EX1/EX2 register
    // --------------------------------------------------
    // Control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex2_valid_o  <= 1'b0;
            ex2_op_o     <= OP_ADD;
            ex2_active_o <= 1'b0;
            ex2_head_o   <= 1'b0;
            ex2_end_o    <= 1'b0;
            ex2_done_o   <= 1'b0;
        end else begin
            ex2_valid_o  <= valid_i;
            ex2_op_o     <= op_i;
            ex2_active_o <= active_i;
            ex2_head_o   <= head_i;
            ex2_end_o    <= end_i;
            // Everything except the multiply is final after EX1
            ex2_done_o   <= valid_i && (op_i != OP_MUL);
        end
    end

    // Payload, loaded on valid beats only
    always_ff @(posedge clk) begin
        if (valid_i) begin
            ex2_res_o    <= alu_res;
            ex2_pp_ll_o  <= pp_ll;
            ex2_pp_lh_o  <= pp_lh;
            ex2_pp_hl_o  <= pp_hl;
            ex2_scalar_o <= a_i;
        end
    end

    // Run flags belong to reductions only
    a_flags_rdc_only: assert property (
        @(posedge clk) disable iff (!rst_n)
        (valid_i && !is_rdc) |-> !(head_i || end_i)
    ) else $error("head/end flag on element-wise op %s", op_i.name());

endmodule

// File: source/vlane_pkg.sv
// Shared types of the vector lane
// Opcode enum, element word type and opcode class helper

`include "vlane_defines.svh"

package vlane_pkg;

    // Element word
    typedef logic [`VLANE_DATA_W-1:0] vlane_word_t;

    // --------------------------------------------------
    // Opcodes
    // --------------------------------------------------
    typedef enum logic [3:0] {
        // Element-wise ops
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_MUL  = 4'h5,
        // In-lane reductions
        OP_RSUM = 4'h8,
        OP_RAND = 4'h9,
        OP_ROR  = 4'hA,
        OP_RXOR = 4'hB
    } vlane_op_e;

    // Reduction ops sit in the upper half of the encoding
    function automatic logic op_is_rdc(vlane_op_e op);
        return op[3];
    endfunction

endpackage

// File: source/vlane_rdc_wb.sv
// Writeback stage of the vector lane
// Folds reduction runs into the accumulator and registers the writeback
// of element results on every beat and of reductions on the end element

module vlane_rdc_wb (
    input  logic                   clk,
    input  logic                   rst_n,
    // EX4 stage in
    input  logic                   ex4_valid_i,
    input  vlane_pkg::vlane_op_e   ex4_op_i,
    input  logic                   ex4_active_i,
    input  logic                   ex4_head_i,
    input  logic                   ex4_end_i,
    input  vlane_pkg::vlane_word_t ex4_res_i,
    input  vlane_pkg::vlane_word_t ex4_scalar_i,
    // Writeback
    output logic                   wr_en_o,
    output vlane_pkg::vlane_word_t wr_data_o,
    output logic                   rdc_done_o
);
    import vlane_pkg::*;

    logic        rdc_vld;
    logic        rdc_end;
    vlane_word_t acc_q;
    vlane_word_t acc_nxt;
    vlane_word_t scalar_q;
    vlane_word_t scalar_sel;
    vlane_word_t rdc_final;
    vlane_word_t elem_data;

    // Combine two values under a reduction op
    function automatic vlane_word_t rdc_fold(vlane_op_e op, vlane_word_t x, vlane_word_t y);
        case (op)
            OP_RAND: return x & y;
            OP_ROR:  return x | y;
            OP_RXOR: return x ^ y;
            default: return x + y;
        endcase
    endfunction

    // Neutral start value when the head element is masked off
    function automatic vlane_word_t rdc_ident(vlane_op_e op);
        return (op == OP_RAND) ? '1 : '0;
    endfunction

    // --------------------------------------------------
    // Reduction accumulator
    // --------------------------------------------------
    assign rdc_vld = ex4_valid_i && op_is_rdc(ex4_op_i);
    assign rdc_end = rdc_vld && ex4_end_i;

    always_comb begin
        if (ex4_head_i) begin
            acc_nxt = ex4_active_i ? ex4_res_i : rdc_ident(ex4_op_i);
        end else if (ex4_active_i) begin
            acc_nxt = rdc_fold(ex4_op_i, acc_q, ex4_res_i);
        end else begin
            // Masked element keeps the running value
            acc_nxt = acc_q;
        end
    end

    // Single-element runs take the scalar straight from EX4
    assign scalar_sel = ex4_head_i ? ex4_scalar_i : scalar_q;
    assign rdc_final  = rdc_fold(ex4_op_i, acc_nxt, scalar_sel);

    always_ff @(posedge clk) begin
        if (rdc_vld) begin
            acc_q <= acc_nxt;
        end
        if (rdc_vld && ex4_head_i) begin
            scalar_q <= ex4_scalar_i;
        end
    end

    // --------------------------------------------------
    // Writeback register
    // --------------------------------------------------
    // Inactive elements still write zero data
    assign elem_data = ex4_active_i ? ex4_res_i : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en_o    <= 1'b0;
            rdc_done_o <= 1'b0;
        end else begin
            // Only the end element of a run writes back
            wr_en_o    <= ex4_valid_i && (!op_is_rdc(ex4_op_i) || ex4_end_i);
            rdc_done_o <= rdc_end;
        end
    end

    always_ff @(posedge clk) begin
        if (ex4_valid_i) begin
            wr_data_o <= rdc_end ? rdc_final : elem_data;
        end
    end

endmodule

// File: source/vlane_top.sv
// Top level of one vector execution lane
// Issue stage, EX2 to EX4 pipe and reduction/writeback stage in a row

module vlane_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // Issue
    input  logic                   valid_i,
    input  vlane_pkg::vlane_op_e   op_i,
    input  vlane_pkg::vlane_word_t a_i,
    input  vlane_pkg::vlane_word_t b_i,
    input  logic                   active_i,
    input  logic                   head_i,
    input  logic                   end_i,
    // Forward points
    output logic                   frw_a_en_o,
    output vlane_pkg::vlane_word_t frw_a_data_o,
    output logic                   frw_b_en_o,
    output vlane_pkg::vlane_word_t frw_b_data_o,
    // Writeback
    output logic                   wr_en_o,
    output vlane_pkg::vlane_word_t wr_data_o,
    output logic                   rdc_done_o
);
    import vlane_pkg::*;

    // --------------------------------------------------
    // Issue to pipe, EX2
    // --------------------------------------------------
    logic        ex2_valid;
    vlane_op_e   ex2_op;
    logic        ex2_active;
    logic        ex2_head;
    logic        ex2_end;
    logic        ex2_done;
    vlane_word_t ex2_res;
    vlane_word_t ex2_pp_ll;
    vlane_word_t ex2_pp_lh;
    vlane_word_t ex2_pp_hl;
    vlane_word_t ex2_scalar;

    // Pipe to writeback, EX4
    logic        ex4_valid;
    vlane_op_e   ex4_op;
    logic        ex4_active;
    logic        ex4_head;
    logic        ex4_end;
    vlane_word_t ex4_res;
    vlane_word_t ex4_scalar;

    vlane_issue u_issue (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_i      (valid_i),
        .op_i         (op_i),
        .a_i          (a_i),
        .b_i          (b_i),
        .active_i     (active_i),
        .head_i       (head_i),
        .end_i        (end_i),
        .frw_a_en_o   (frw_a_en_o),
        .frw_a_data_o (frw_a_data_o),
        .ex2_valid_o  (ex2_valid),
        .ex2_op_o     (ex2_op),
        .ex2_active_o (ex2_active),
        .ex2_head_o   (ex2_head),
        .ex2_end_o    (ex2_end),
        .ex2_done_o   (ex2_done),
        .ex2_res_o    (ex2_res),
        .ex2_pp_ll_o  (ex2_pp_ll),
        .ex2_pp_lh_o  (ex2_pp_lh),
        .ex2_pp_hl_o  (ex2_pp_hl),
        .ex2_scalar_o (ex2_scalar)
    );

    vlane_ex_pipe u_ex_pipe (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex2_valid_i  (ex2_valid),
        .ex2_op_i     (ex2_op),
        .ex2_active_i (ex2_active),
        .ex2_head_i   (ex2_head),
        .ex2_end_i    (ex2_end),
        .ex2_done_i   (ex2_done),
        .ex2_res_i    (ex2_res),
        .ex2_pp_ll_i  (ex2_pp_ll),
        .ex2_pp_lh_i  (ex2_pp_lh),
        .ex2_pp_hl_i  (ex2_pp_hl),
        .ex2_scalar_i (ex2_scalar),
        .ex4_valid_o  (ex4_valid),
        .ex4_op_o     (ex4_op),
        .ex4_active_o (ex4_active),
        .ex4_head_o   (ex4_head),
        .ex4_end_o    (ex4_end),
        .ex4_res_o    (ex4_res),
        .ex4_scalar_o (ex4_scalar),
        .frw_b_en_o   (frw_b_en_o),
        .frw_b_data_o (frw_b_data_o)
    );

    vlane_rdc_wb u_rdc_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex4_valid_i  (ex4_valid),
        .ex4_op_i     (ex4_op),
        .ex4_active_i (ex4_active),
        .ex4_head_i   (ex4_head),
        .ex4_end_i    (ex4_end),
        .ex4_res_i    (ex4_res),
        .ex4_scalar_i (ex4_scalar),
        .wr_en_o      (wr_en_o),
        .wr_data_o    (wr_data_o),
        .rdc_done_o   (rdc_done_o)
    );

endmodule
